// ==== verilog.f ====
+incdir+src
src/clk_ratio_pkg.sv
src/trigger_sync.sv
src/ratio_counter_bank.sv
src/measure_ctrl.sv
src/sample_fifo.sv
src/ratio_reporter.sv
src/clk_ratio_top.sv
sim/clk_ratio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module clk_ratio_tb \
  -f verilog.f \
  -o clk_ratio_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/clk_ratio_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'Verification passed'; then
  exit 0
fi
exit 1

// ==== sim/clk_ratio_tb.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module clk_ratio_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import clk_ratio_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int PATH_DEPTH    = `CR_FIFO_DEPTH + 2;
  localparam int WINDOW_CYCLES = int'(`CR_GATE_LIMIT) + 64;
  // four single measurements plus one full path of back-pressured ones
  localparam int MEAS_TOTAL    = 4 + PATH_DEPTH;
  localparam int WATCHDOG_NS   = MEAS_TOTAL * WINDOW_CYCLES * CLK_PERIOD;
  localparam int COUNT_TOL     = 3;

  logic                    clk_in;
  logic                    rst_n;
  logic [`CR_CHANNELS-1:0] meas_clk;
  logic                    run;
  logic                    busy;
  logic                    result_valid;
  logic                    result_ready;
  result_t                 result;

  // half period of each measured clock in ns where zero holds that clock low
  int unsigned half_ns [`CR_CHANNELS];
  int          errors;
  int          checks;
  int          seed;

  clk_ratio_top i_dut (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .meas_clk     (meas_clk),
    .run          (run),
    .busy         (busy),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  // --------------------------------------------------
  // system clock
  initial
  begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  // each measured clock runs on its own
  // the 1 ns start offset keeps its edges away from the system clock edges
  for (genvar j = 0; j < `CR_CHANNELS; j++)
  begin : g_meas_clk
    logic clk_q;

    initial
    begin
      clk_q = 1'b0;
      #1;
      forever
      begin
        if (half_ns[j] == 0)
        begin
          clk_q = 1'b0;
          #5;
        end
        else
        begin
          #(half_ns[j]) clk_q = 1'b1;
          #(half_ns[j]) clk_q = 1'b0;
        end
      end
    end

    assign meas_clk[j] = clk_q;
  end

  // --------------------------------------------------
  // stimulus helpers
  task automatic set_periods(input int unsigned p0, input int unsigned p1, input int unsigned p2);
    half_ns[0] = p0 / 2;
    half_ns[1] = p1 / 2;
    half_ns[2] = p2 / 2;
  endtask

  // the masked clocks stop halfway through reset so their counters stay at zero
  task automatic apply_reset(input logic [`CR_CHANNELS-1:0] stop_mask);
    @(posedge clk_in);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk_in);
    for (int j = 0; j < `CR_CHANNELS; j++)
    begin
      if (stop_mask[j])
      begin
        half_ns[j] = 0;
      end
    end
    repeat (2) @(posedge clk_in);
    rst_n <= 1'b1;
  endtask

  // a one cycle run pulse gives exactly one measurement window
  task automatic start_measurement();
    @(posedge clk_in);
    run          <= 1'b1;
    result_ready <= 1'b1;
    @(posedge clk_in);
    run <= 1'b0;
  endtask

  task automatic wait_result(output result_t r, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    r      = '0;
    while (!ok && (cycles < WINDOW_CYCLES))
    begin
      @(posedge clk_in);
      if (result_valid && result_ready)
      begin
        r  = result;
        ok = 1'b1;
      end
      cycles++;
    end
    if (!ok)
    begin
      $display("Error at %0t ns: no result arrived within %0d clock cycles", $time, WINDOW_CYCLES);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // compare tasks
  task automatic check_count(input count_t actual, input count_t expected, input int tol,
                             input string what);
    int diff;
    diff = int'(actual) - int'(expected);
    checks++;
    if ((diff > tol) || (diff < -tol))
    begin
      $display("Mismatch at %0t ns: %s count %0d, expected %0d within %0d",
               $time, what, actual, expected, tol);
      errors++;
    end
  endtask

  task automatic check_result_flags(input result_t actual, input chan_idx_t fastest,
                                    input logic saturated, input logic timed_out,
                                    input logic [`CR_CHANNELS-1:0] stopped, input string what);
    checks++;
    if ((actual.fastest !== fastest) || (actual.saturated !== saturated) ||
        (actual.sample.timed_out !== timed_out) || (actual.stopped !== stopped))
    begin
      $display("Mismatch at %0t ns: %s fastest %0d sat %b timeout %b stopped %b, exp %0d %b %b %b",
               $time, what, actual.fastest, actual.saturated, actual.sample.timed_out,
               actual.stopped, fastest, saturated, timed_out, stopped);
      errors++;
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // expected values from the clock periods
  // the fastest channel reaches full scale and the others scale by period ratio
  function automatic count_t ratio_count(input int unsigned p_fast, input int unsigned p_chan);
    int unsigned full;
    full = (1 << `CR_COUNT_W) - 1;
    return count_t'((full * p_fast + p_chan / 2) / p_chan);
  endfunction

  task automatic check_measurement(input result_t r, input string name);
    int unsigned             fast_per;
    chan_idx_t               exp_fastest;
    logic                    exp_sat;
    logic [`CR_CHANNELS-1:0] exp_stopped;
    count_t                  exp_cnt;
    int                      tol;
    fast_per    = 0;
    exp_fastest = '0;
    exp_sat     = 1'b0;
    exp_stopped = '0;
    // the lowest numbered channel with the shortest period wins a tie
    for (int j = 0; j < `CR_CHANNELS; j++)
    begin
      if (half_ns[j] == 0)
      begin
        exp_stopped[j] = 1'b1;
      end
      else if (!exp_sat || (2 * half_ns[j] < fast_per))
      begin
        fast_per    = 2 * half_ns[j];
        exp_fastest = chan_idx_t'(j);
        exp_sat     = 1'b1;
      end
    end
    // with no running clock the gate limit ends the window
    check_result_flags(r, exp_fastest, exp_sat, !exp_sat, exp_stopped, name);
    for (int j = 0; j < `CR_CHANNELS; j++)
    begin
      if (exp_stopped[j])
      begin
        exp_cnt = '0;
        tol     = 0;
      end
      else if (chan_idx_t'(j) == exp_fastest)
      begin
        exp_cnt = '1;
        tol     = 0;
      end
      else
      begin
        exp_cnt = ratio_count(fast_per, 2 * half_ns[j]);
        tol     = COUNT_TOL;
      end
      check_count(r.sample.counts[j], exp_cnt, tol, $sformatf("%s ch%0d", name, j));
    end
  endtask

  // --------------------------------------------------
  // directed tests
  task automatic measure_basic_ratio();
    result_t r;
    bit      ok;
    set_periods(20, 30, 50);
    start_measurement();
    wait_result(r, ok);
    if (ok)
    begin
      check_measurement(r, "basic ratio");
    end
  endtask

  task automatic move_fastest_channel();
    result_t r;
    bit      ok;
    set_periods(40, 16, 24);
    repeat (2) @(posedge clk_in);
    start_measurement();
    wait_result(r, ok);
    if (ok)
    begin
      check_measurement(r, "fastest moved");
    end
  endtask

  task automatic flag_stopped_clock();
    result_t r;
    bit      ok;
    set_periods(20, 30, 50);
    apply_reset(3'b100);
    start_measurement();
    wait_result(r, ok);
    if (ok)
    begin
      check_measurement(r, "stopped clock");
    end
  endtask

  task automatic expire_gate_limit();
    result_t r;
    bit      ok;
    apply_reset(3'b111);
    start_measurement();
    wait_result(r, ok);
    if (ok)
    begin
      check_measurement(r, "timeout");
    end
  endtask

  // fills the reporter, the FIFO and the controller, then drains them
  task automatic drain_after_backpressure();
    logic [31:0] rand_val;
    int          low_cycles;
    int          waited;
    int          got;
    low_cycles = 0;
    waited     = 0;
    got        = 0;
    set_periods(20, 30, 50);
    @(posedge clk_in);
    result_ready <= 1'b0;
    run          <= 1'b1;
    // busy stays low once the controller holds a sample it cannot push
    while ((low_cycles < 16) && (waited < PATH_DEPTH * WINDOW_CYCLES))
    begin
      @(posedge clk_in);
      if (busy)
      begin
        low_cycles = 0;
      end
      else
      begin
        low_cycles++;
      end
      waited++;
    end
    if (low_cycles < 16)
    begin
      $display("Error at %0t ns: busy never dropped while result_ready was held low", $time);
      errors++;
    end
    check_bit(result_valid, 1'b1, "result_valid with a full path");
    run    <= 1'b0;
    waited = 0;
    while ((got < PATH_DEPTH) && (waited < PATH_DEPTH * WINDOW_CYCLES))
    begin
      @(posedge clk_in);
      if (result_valid && result_ready)
      begin
        got++;
        check_measurement(result, $sformatf("backpressure result %0d", got));
      end
      rand_val = $random(seed);
      result_ready <= rand_val[0];
      waited++;
    end
    if (got < PATH_DEPTH)
    begin
      $display("Error at %0t ns: only %0d of %0d held results were delivered",
               $time, got, PATH_DEPTH);
      errors++;
    end
    // nothing may follow once the path is empty
    repeat (64)
    begin
      @(posedge clk_in);
      if (result_valid && result_ready)
      begin
        $display("Error at %0t ns: an extra result was delivered after the path drained", $time);
        errors++;
      end
      rand_val = $random(seed);
      result_ready <= rand_val[0];
    end
  endtask

  // --------------------------------------------------
  // main sequence
  initial
  begin
    rst_n        = 1'b0;
    run          = 1'b0;
    result_ready = 1'b0;
    seed         = 32'h4058;
    errors       = 0;
    checks       = 0;
    set_periods(20, 30, 50);
    apply_reset('0);
    measure_basic_ratio();
    move_fastest_channel();
    flag_stopped_clock();
    expire_gate_limit();
    drain_after_backpressure();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog sized for every measurement window running to the gate limit
  initial
  begin
    #(WATCHDOG_NS);
    $display("Error at %0t ns: simulation timed out before the tests finished", $time);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/clk_ratio_top.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module clk_ratio_top (
  input  logic                    clk_in,
  input  logic                    rst_n,
  input  logic [`CR_CHANNELS-1:0] meas_clk,
  input  logic                    run,
  output logic                    busy,
  output logic                    result_valid,
  input  logic                    result_ready,
  output clk_ratio_pkg::result_t  result
);

  import clk_ratio_pkg::*;

  // --------------------------------------------------
  // measured clock side
  count_t [`CR_CHANNELS-1:0] counts;
  logic [`CR_CHANNELS-1:0]   sat;
  logic                      trigger;

  // system side sample path
  sample_t ctrl_sample;
  logic    ctrl_valid;
  logic    ctrl_ready;
  sample_t fifo_sample;
  logic    fifo_valid;
  logic    fifo_ready;

  ratio_counter_bank i_counter_bank (
    .meas_clk (meas_clk),
    .rst_n    (rst_n),
    .trigger  (trigger),
    .counts   (counts),
    .sat      (sat)
  );

  // the controller produces one sample per window
  measure_ctrl i_measure_ctrl (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .run          (run),
    .counts       (counts),
    .sat          (sat),
    .trigger      (trigger),
    .busy         (busy),
    .sample_valid (ctrl_valid),
    .sample_ready (ctrl_ready),
    .sample       (ctrl_sample)
  );

  sample_fifo i_sample_fifo (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .in_valid  (ctrl_valid),
    .in_ready  (ctrl_ready),
    .in_data   (ctrl_sample),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_sample)
  );

  // the reporter turns samples into results on the external handshake
  ratio_reporter i_ratio_reporter (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .in_valid     (fifo_valid),
    .in_ready     (fifo_ready),
    .in_data      (fifo_sample),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== src/ratio_reporter.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module ratio_reporter (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  clk_ratio_pkg::sample_t in_data,
  output logic                   result_valid,
  input  logic                   result_ready,
  output clk_ratio_pkg::result_t result
);

  import clk_ratio_pkg::*;

  localparam count_t FULL_SCALE = '1;

  result_t next_result;
  logic    take;

  // --------------------------------------------------
  // decode the sample
  // scanning from the top down leaves the lowest saturated channel in fastest
  always_comb
  begin
    next_result.sample    = in_data;
    next_result.fastest   = '0;
    next_result.saturated = 1'b0;
    next_result.stopped   = '0;
    for (int j = `CR_CHANNELS - 1; j >= 0; j--)
    begin
      if (in_data.counts[j] == FULL_SCALE)
      begin
        next_result.fastest   = chan_idx_t'(j);
        next_result.saturated = 1'b1;
      end
      // a clock that never ticked leaves its counter at zero
      next_result.stopped[j] = (in_data.counts[j] == '0);
    end
  end

  // --------------------------------------------------
  // one entry output stage
  // a new sample is accepted when the stage is empty or drains this cycle
  assign in_ready = !result_valid || result_ready;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk_in)
  begin
    if (!rst_n)
    begin
      result_valid <= 1'b0;
    end
    else if (take)
    begin
      result_valid <= 1'b1;
    end
    else if (result_ready)
    begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (take)
    begin
      result <= next_result;
    end
  end

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module sample_fifo (
  input  logic                   clk_in,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  clk_ratio_pkg::sample_t in_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output clk_ratio_pkg::sample_t out_data
);

  import clk_ratio_pkg::*;

  localparam int unsigned PTR_W = $clog2(`CR_FIFO_DEPTH);

  // occupancy needs one more bit than the pointers to tell full from empty
  localparam logic [PTR_W:0] FULL_COUNT = `CR_FIFO_DEPTH;

  sample_t          mem [`CR_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   occupancy;
  logic             push;
  logic             pop;

  assign in_ready  = (occupancy != FULL_COUNT);
  assign out_valid = (occupancy != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // --------------------------------------------------
  // storage, the pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_in)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_data;
    end
  end

  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk_in)
  begin
    if (!rst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // --------------------------------------------------
  // a full FIFO must not take another entry from the controller
  a_no_write_full : assert property (
    @(posedge clk_in) disable iff (!rst_n)
    (occupancy == FULL_COUNT) |=> $stable(wr_ptr)
  );

  // an empty FIFO must not hand anything to the reporter
  a_no_read_empty : assert property (
    @(posedge clk_in) disable iff (!rst_n)
    (occupancy == '0) |=> $stable(rd_ptr)
  );

endmodule

`default_nettype wire

// ==== src/measure_ctrl.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module measure_ctrl (
  input  logic                                     clk_in,
  input  logic                                     rst_n,
  input  logic                                     run,
  input  clk_ratio_pkg::count_t [`CR_CHANNELS-1:0] counts,
  input  logic [`CR_CHANNELS-1:0]                  sat,
  output logic                                     trigger,
  output logic                                     busy,
  output logic                                     sample_valid,
  input  logic                                     sample_ready,
  output clk_ratio_pkg::sample_t                   sample
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_TRIG,
    ST_GATE,
    ST_SETTLE,
    ST_PRESENT
  } state_t;

  state_t                  state;
  logic [15:0]             cycle_cnt;
  logic [`CR_CHANNELS-1:0] sat_meta;
  logic [`CR_CHANNELS-1:0] sat_sync;
  logic                    any_sat;

  // --------------------------------------------------
  // two flop synchronizer for the saturation flags of every channel
  always_ff @(posedge clk_in)
  begin
    if (!rst_n)
    begin
      sat_meta <= '0;
      sat_sync <= '0;
    end
    else
    begin
      sat_meta <= sat;
      sat_sync <= sat_meta;
    end
  end

  assign any_sat = |sat_sync;

  // --------------------------------------------------
  // window sequencer
  // the cycle counter keeps running from the trigger rise through the gate
  // wait so the limit is measured from the start of the window
  always_ff @(posedge clk_in)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cycle_cnt <= '0;
      trigger   <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (run)
          begin
            state     <= ST_TRIG;
            cycle_cnt <= '0;
            trigger   <= 1'b1;
          end
        end
        ST_TRIG:
        begin
          cycle_cnt <= cycle_cnt + 16'd1;
          if (cycle_cnt == 16'(`CR_TRIG_HOLD - 1))
          begin
            state   <= ST_GATE;
            trigger <= 1'b0;
          end
        end
        ST_GATE:
        begin
          cycle_cnt <= cycle_cnt + 16'd1;
          if (any_sat || (cycle_cnt == `CR_GATE_LIMIT - 16'd1))
          begin
            state     <= ST_SETTLE;
            cycle_cnt <= '0;
          end
        end
        ST_SETTLE:
        begin
          cycle_cnt <= cycle_cnt + 16'd1;
          if (cycle_cnt == 16'(`CR_SETTLE_CYCLES - 1))
          begin
            state <= ST_PRESENT;
          end
        end
        ST_PRESENT:
        begin
          // a new window starts right after the transfer when run is still high
          if (sample_ready)
          begin
            if (run)
            begin
              state     <= ST_TRIG;
              cycle_cnt <= '0;
              trigger   <= 1'b1;
            end
            else
            begin
              state <= ST_IDLE;
            end
          end
        end
        default:
        begin
          state   <= ST_IDLE;
          trigger <= 1'b0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // sample payload
  // timed_out follows the gate wait and keeps the value of its last cycle
  // the counts are frozen by now so sampling them across domains is safe
  always_ff @(posedge clk_in)
  begin
    if (state == ST_GATE)
    begin
      sample.timed_out <= ~any_sat;
    end
    if ((state == ST_SETTLE) && (cycle_cnt == 16'(`CR_SETTLE_CYCLES - 1)))
    begin
      sample.counts <= counts;
    end
  end

  assign sample_valid = (state == ST_PRESENT);
  assign busy         = (state == ST_TRIG) || (state == ST_GATE) || (state == ST_SETTLE);

  // a presented sample must not change while the FIFO holds it off
  a_sample_hold : assert property (
    @(posedge clk_in) disable iff (!rst_n)
    (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample))
  );

endmodule

`default_nettype wire

// ==== src/ratio_counter_bank.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

module ratio_counter_bank (
  input  logic [`CR_CHANNELS-1:0]                     meas_clk,
  input  logic                                        rst_n,
  input  logic                                        trigger,
  output clk_ratio_pkg::count_t [`CR_CHANNELS-1:0]    counts,
  output logic [`CR_CHANNELS-1:0]                     sat
);

  import clk_ratio_pkg::*;

  // any channel at full scale stops every channel
  // this signal is sampled by every measured clock without synchronization
  // and the resulting one count uncertainty is within the measurement tolerance
  logic any_sat;

  assign any_sat = |sat;

  // --------------------------------------------------
  // one trigger synchronizer and one counter per measured clock
  for (genvar j = 0; j < `CR_CHANNELS; j++)
  begin : g_chan

    logic   trig_rise;
    count_t cnt;

    // only the rising edge is used to start a run
    trigger_sync i_trigger_sync (
      .trigger      (trigger),
      .meas_clk     (meas_clk[j]),
      .rst_n        (rst_n),
      .trigger_meas (),
      .rise         (trig_rise),
      .fall         ()
    );

    // the counter restarts from zero on the trigger edge and then counts
    // until this or any other channel reaches full scale
    always_ff @(posedge meas_clk[j])
    begin
      if (!rst_n || trig_rise)
      begin
        cnt <= '0;
      end
      else if (!any_sat)
      begin
        cnt <= cnt + count_t'(1);
      end
    end

    assign sat[j]    = &cnt;
    assign counts[j] = cnt;

    // once a channel is full it must hold its value until the next trigger
    // otherwise the fastest channel would wrap and lose its full scale mark
    a_sat_frozen : assert property (
      @(posedge meas_clk[j]) disable iff (!rst_n)
      (sat[j] && !trig_rise) |=> $stable(cnt)
    );

  end

endmodule

`default_nettype wire

// ==== src/trigger_sync.sv ====
`default_nettype none

module trigger_sync (
  input  logic trigger,
  input  logic meas_clk,
  input  logic rst_n,
  output logic trigger_meas,
  output logic rise,
  output logic fall
);

  // three stage shift register in the measured domain
  // stage 0 may go metastable, stage 1 is the first safe copy
  // and stage 2 holds the previous safe value for edge detection
  logic [2:0] sync_q;

  // --------------------------------------------------
  // the reset is only sampled by this clock, so a stopped clock keeps
  // its old state until it starts toggling again
  always_ff @(posedge meas_clk)
  begin
    if (!rst_n)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q <= {sync_q[1:0], trigger};
    end
  end

  // --------------------------------------------------
  // level of the trigger as seen in this domain
  assign trigger_meas = sync_q[2];

  // each edge lasts exactly one measured clock cycle
  assign rise = sync_q[1] & ~sync_q[2];
  assign fall = ~sync_q[1] & sync_q[2];

endmodule

`default_nettype wire

// ==== src/clk_ratio_pkg.sv ====
`default_nettype none

`include "clk_ratio_config.svh"

package clk_ratio_pkg;

  // --------------------------------------------------
  // one channel's cycle count in its own clock domain
  typedef logic [`CR_COUNT_W-1:0] count_t;

  // wide enough to name any measured channel
  typedef logic [$clog2(`CR_CHANNELS)-1:0] chan_idx_t;

  // --------------------------------------------------
  // frozen counts captured at the end of one measurement window
  // timed_out is set when the gate limit ended the window instead of saturation
  typedef struct packed {
    count_t [`CR_CHANNELS-1:0] counts;
    logic                      timed_out;
  } sample_t;

  // --------------------------------------------------
  // the sample plus what the reporter decodes from it
  // fastest is the lowest-numbered channel at full scale and is only
  // meaningful when saturated is set
  // a stopped bit marks a channel whose count stayed at zero
  typedef struct packed {
    sample_t                 sample;
    chan_idx_t               fastest;
    logic                    saturated;
    logic [`CR_CHANNELS-1:0] stopped;
  } result_t;

endpackage

`default_nettype wire

// ==== src/clk_ratio_config.svh ====
`ifndef CLK_RATIO_CONFIG_SVH
`define CLK_RATIO_CONFIG_SVH

// number of free-running clocks that are compared against each other
`define CR_CHANNELS 3

// counter width in bits and the all ones value is full scale
`define CR_COUNT_W 8

// sample entries between the controller and the reporter, must be a power of two
`define CR_FIFO_DEPTH 4

// system cycles to wait once saturation is seen so every counter has frozen
`define CR_SETTLE_CYCLES 4

// system cycles the trigger is held high so the slowest clock can catch it
`define CR_TRIG_HOLD 8

// system cycles after the trigger rises before a window is abandoned
`define CR_GATE_LIMIT 16'd2000

`endif
